/* sources.f */
logic/mem_bus_pkg.sv
logic/core_req_pkg.sv
logic/fetch_requester.sv
logic/data_requester.sv
logic/port_arbiter.sv
logic/request_unit_top.sv
bench/bus_responder.sv
bench/tb_request_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_request_unit
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_request_unit.sv */
`timescale 1ns/1ps

module tb_request_unit;
    import mem_bus_pkg::*;
    import core_req_pkg::*;

    localparam int ADDR_W = 12;

    logic              clk;
    logic              rst;
    logic              fetch_req_valid;
    logic [ADDR_W-1:0] fetch_pc;
    logic              fetch_req_ready;
    logic              redirect;
    logic [ADDR_W-1:0] redirect_pc;
    logic              instr_valid;
    logic [DATA_W-1:0] instr;
    logic              instr_ready;
    logic              data_req_valid;
    mem_op_e           data_op;
    logic [ADDR_W-1:0] data_addr;
    logic [DATA_W-1:0] data_wdata;
    logic              data_req_ready;
    logic              data_rsp_valid;
    logic [DATA_W-1:0] data_rdata;
    logic              mem_valid;
    mem_op_e           mem_op;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic              mem_ready;
    logic              mem_rsp_valid;
    logic [DATA_W-1:0] mem_rdata;
    logic              freeze;

    integer            seed;
    integer            mem_seed;
    int                errors;
    int                tests;
    int                failed;
    int                nop_seen;
    int                discard_cycles;
    string             test_name;
    logic [DATA_W-1:0] model_mem [0:1023];
    logic              f_inflight;   // Fetch taken and not yet handed over
    logic              f_stale;
    logic [ADDR_W-1:0] f_addr_m;
    logic [ADDR_W-1:0] f_target;
    logic              held_valid;
    logic [DATA_W-1:0] held_instr;
    logic [DATA_W-1:0] exp_word;
    logic              d_pending;
    mem_op_e           d_op_m;
    logic [ADDR_W-1:0] d_addr_m;
    logic [DATA_W-1:0] d_wdata_m;
    logic              bus_wait;
    logic [ADDR_W-1:0] bus_addr;

    request_unit_top #(.ADDR_W(ADDR_W)) dut (.*);

    bus_responder #(.ADDR_W(ADDR_W)) u_mem (
        .clk, .rst, .mem_valid, .mem_op, .mem_addr, .mem_wdata,
        .mem_ready, .mem_rsp_valid, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic value_error(input string what, input logic [31:0] e, input logic [31:0] a);
        $display("** Error: %s: %s expected %h, actual %h", test_name, what, e, a);
        errors++;
    endtask

    task automatic fault(input string what);
        $display("%s: %s", test_name, what);
        errors++;
    endtask

    // Reference model and protocol checks, all on pre-edge values
    always @(posedge clk) begin
        if (!rst) begin
            if (dut.u_fetch.state == FS_DISCARD)
                discard_cycles++;
            if ((f_inflight && !instr_valid) || (d_pending && !data_rsp_valid))
                assert (freeze) else fault("freeze low while a request is in flight");
            if ((!f_inflight || (instr_valid && !f_stale)) && !d_pending)
                assert (!freeze) else fault("freeze high with both sides idle");
            if (bus_wait)
                assert (mem_valid && mem_addr == bus_addr)
                    else fault("bus request dropped or changed before mem_ready");
            bus_wait = mem_valid && !mem_ready;
            bus_addr = mem_addr;
            // Every bus transfer must carry the request of its owner
            if (mem_valid && mem_ready) begin
                if (mem_op == OP_FETCH) begin
                    assert (f_inflight) else fault("fetch on the bus with no fetch outstanding");
                    assert (mem_addr == f_addr_m)
                        else value_error("fetch address", 32'(f_addr_m), 32'(mem_addr));
                end else begin
                    assert (d_pending) else fault("data access on the bus with none outstanding");
                    assert (mem_op == d_op_m)
                        else value_error("bus op", 32'(d_op_m), 32'(mem_op));
                    assert (mem_addr == d_addr_m)
                        else value_error("data address", 32'(d_addr_m), 32'(mem_addr));
                    if (d_op_m == OP_STORE)
                        assert (mem_wdata == d_wdata_m)
                            else value_error("store data", d_wdata_m, mem_wdata);
                end
            end
            if (held_valid)
                assert (instr_valid && instr == held_instr)
                    else value_error("held instr", held_instr, instr);
            held_valid = instr_valid && !instr_ready;
            held_instr = instr;
            if (redirect && !fetch_req_ready && f_inflight) begin
                if (!instr_valid)
                    f_stale = 1'b1;
                if (!instr_valid || f_stale)
                    f_target = redirect_pc;  // Newest target wins
            end
            if (instr_valid && instr_ready) begin
                assert (f_inflight) else fault("instr_valid with no fetch outstanding");
                exp_word = f_stale ? NOP_INSTR : model_mem[f_addr_m[11:2]];
                assert (instr == exp_word) else value_error("instr", exp_word, instr);
                if (f_stale) begin
                    nop_seen++;
                    f_addr_m = f_target;
                    f_stale  = 1'b0;
                end else begin
                    f_inflight = 1'b0;
                end
            end
            if (fetch_req_valid && fetch_req_ready) begin
                f_inflight = 1'b1;
                f_stale    = 1'b0;
                f_addr_m   = fetch_pc;
            end
            if (data_rsp_valid) begin
                assert (d_pending) else fault("data_rsp_valid with no request outstanding");
                if (d_op_m == OP_LOAD)
                    assert (data_rdata == model_mem[d_addr_m[11:2]])
                        else value_error("load data", model_mem[d_addr_m[11:2]], data_rdata);
                else
                    model_mem[d_addr_m[11:2]] = d_wdata_m;
                d_pending = 1'b0;
            end
            if (data_req_valid && data_req_ready) begin
                d_pending = 1'b1;
                d_op_m    = data_op;
                d_addr_m  = data_addr;
                d_wdata_m = data_wdata;
            end
        end
    end

    // Fetches use the lower half of memory, loads and stores the upper half
    task automatic run_traffic(input string name, input int nf, input int nd,
                               input bit redir, input int limit);
        int f_issued;
        int d_issued;
        int cyc;
        int start_errs;
        bit done;
        f_issued   = 0;
        d_issued   = 0;
        cyc        = 0;
        done       = 1'b0;
        start_errs = errors;
        test_name  = name;
        nop_seen   = 0;
        while (!done && cyc < limit) begin
            @(posedge clk);
            cyc++;
            done = f_issued == nf && d_issued == nd && !f_inflight && !d_pending;
            if (fetch_req_valid && fetch_req_ready)
                f_issued++;
            if (data_req_valid && data_req_ready)
                d_issued++;
            if (!(fetch_req_valid && !fetch_req_ready)) begin
                fetch_req_valid <= f_issued < nf && (($random(seed) & 3) == 0);
                fetch_pc        <= {1'b0, 9'($random(seed)), 2'b00};
            end
            if (!(data_req_valid && !data_req_ready)) begin
                data_req_valid <= d_issued < nd && (($random(seed) & 3) == 0);
                data_op        <= (($random(seed) & 1) == 1) ? OP_STORE : OP_LOAD;
                data_addr      <= {1'b1, 9'($random(seed)), 2'b00};
                data_wdata     <= $random(seed);
            end
            instr_ready <= ($random(seed) & 1) == 1;
            redirect    <= redir && f_issued < nf && (($random(seed) & 7) == 0);
            redirect_pc <= {1'b0, 9'($random(seed)), 2'b00};
        end
        fetch_req_valid <= 1'b0;
        data_req_valid  <= 1'b0;
        redirect        <= 1'b0;
        if (!done)
            fault($sformatf("timeout after %0d cycles, %0d/%0d fetches, %0d/%0d data ops",
                            cyc, f_issued, nf, d_issued, nd));
        if (redir)
            assert (nop_seen > 0) else fault("no redirect squashed a fetch");
        tests++;
        if (errors != start_errs)
            failed++;
        $display("%s: %s (%0d errors)", name, (errors == start_errs) ? "PASS" : "FAIL",
                 errors - start_errs);
    endtask

    initial begin
        seed            = 32'h3ff2_8e88;
        mem_seed        = 32'h3ff2_8e88;  // Same fill as the responder
        errors          = 0;
        tests           = 0;
        failed          = 0;
        discard_cycles  = 0;
        test_name       = "reset";
        f_inflight      = 1'b0;
        f_stale         = 1'b0;
        held_valid      = 1'b0;
        d_pending       = 1'b0;
        bus_wait        = 1'b0;
        rst             = 1'b1;
        fetch_req_valid = 1'b0;
        fetch_pc        = '0;
        redirect        = 1'b0;
        redirect_pc     = '0;
        instr_ready     = 1'b0;
        data_req_valid  = 1'b0;
        data_op         = OP_LOAD;
        data_addr       = '0;
        data_wdata      = '0;
        for (int i = 0; i < 1024; i++)
            model_mem[i] = $random(mem_seed);
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!mem_valid && !instr_valid && !data_rsp_valid && !freeze
                && fetch_req_ready && data_req_ready)
            else fault("outputs not at their idle values after reset");
        run_traffic("fetch only", 200, 0, 1'b0, 20000);
        run_traffic("loads and stores", 0, 200, 1'b0, 20000);
        run_traffic("mixed traffic", 200, 200, 1'b0, 40000);
        run_traffic("redirect", 100, 0, 1'b1, 20000);
        run_traffic("freeze and bus protocol", 100, 100, 1'b1, 40000);
        $display("Tests %0d, failed %0d, errors %0d, discard cycles %0d",
                 tests, failed, errors, discard_cycles);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* bench/bus_responder.sv */
`timescale 1ns/1ps

module bus_responder #(
    parameter int ADDR_W = 12,
    parameter logic [31:0] SEED = 32'h3ff2_8e88
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           mem_valid,
    input  mem_bus_pkg::mem_op_e           mem_op,
    input  logic [ADDR_W-1:0]              mem_addr,
    input  logic [mem_bus_pkg::DATA_W-1:0] mem_wdata,
    output logic                           mem_ready,
    output logic                           mem_rsp_valid,
    output logic [mem_bus_pkg::DATA_W-1:0] mem_rdata
);
    import mem_bus_pkg::*;

    logic [DATA_W-1:0] mem [0:(1<<(ADDR_W-2))-1];
    logic [DATA_W-1:0] rdata_q;
    logic [2:0]        cnt;
    logic              busy;
    integer            fill_seed;
    integer            seed;

    initial begin
        fill_seed = SEED;
        seed      = ~SEED;   // Timing draws stay apart from the fill
        for (int i = 0; i < (1 << (ADDR_W - 2)); i++)
            mem[i] = $random(fill_seed);
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_ready     <= 1'b0;
            mem_rsp_valid <= 1'b0;
            busy          <= 1'b0;
            cnt           <= 3'd0;
        end else begin
            mem_ready     <= ($random(seed) & 1) == 1;
            mem_rsp_valid <= 1'b0;
            if (busy) begin
                if (cnt == 3'd1) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rdata     <= rdata_q;
                    busy          <= 1'b0;
                end else begin
                    cnt <= cnt - 3'd1;
                end
            end else if (mem_valid && mem_ready) begin
                busy    <= 1'b1;
                cnt     <= 3'((($random(seed) & 32'h7fff_ffff) % 6) + 1);  // 1 to 6 cycles
                rdata_q <= mem[mem_addr[ADDR_W-1:2]];
                if (mem_op == OP_STORE)
                    mem[mem_addr[ADDR_W-1:2]] <= mem_wdata;
            end
        end
    end

endmodule

/* logic/request_unit_top.sv */
`timescale 1ns/1ps

module request_unit_top #(
    parameter int ADDR_W = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           fetch_req_valid,
    input  logic [ADDR_W-1:0]              fetch_pc,
    output logic                           fetch_req_ready,
    input  logic                           redirect,
    input  logic [ADDR_W-1:0]              redirect_pc,
    output logic                           instr_valid,
    output logic [mem_bus_pkg::DATA_W-1:0] instr,
    input  logic                           instr_ready,
    input  logic                           data_req_valid,
    input  mem_bus_pkg::mem_op_e           data_op,
    input  logic [ADDR_W-1:0]              data_addr,
    input  logic [mem_bus_pkg::DATA_W-1:0] data_wdata,
    output logic                           data_req_ready,
    output logic                           data_rsp_valid,
    output logic [mem_bus_pkg::DATA_W-1:0] data_rdata,
    output logic                           mem_valid,
    output mem_bus_pkg::mem_op_e           mem_op,
    output logic [ADDR_W-1:0]              mem_addr,
    output logic [mem_bus_pkg::DATA_W-1:0] mem_wdata,
    input  logic                           mem_ready,
    input  logic                           mem_rsp_valid,
    input  logic [mem_bus_pkg::DATA_W-1:0] mem_rdata,
    output logic                           freeze
);
    import mem_bus_pkg::*;

    logic              f_valid;
    logic [ADDR_W-1:0] f_addr;
    logic              f_accept;
    logic              f_rsp_valid;
    logic [DATA_W-1:0] f_rdata;
    logic              f_busy;
    logic              d_valid;
    mem_op_e           d_op;
    logic [ADDR_W-1:0] d_addr;
    logic [DATA_W-1:0] d_wdata;
    logic              d_accept;
    logic              d_rsp_valid;
    logic [DATA_W-1:0] d_rdata;
    logic              d_busy;

    fetch_requester #(.ADDR_W(ADDR_W)) u_fetch (
        .clk, .rst,
        .fetch_req_valid, .fetch_pc, .fetch_req_ready,
        .redirect, .redirect_pc,
        .instr_valid, .instr, .instr_ready,
        .f_valid, .f_addr, .f_accept, .f_rsp_valid, .f_rdata, .f_busy
    );

    data_requester #(.ADDR_W(ADDR_W)) u_data (
        .clk, .rst,
        .data_req_valid, .data_op, .data_addr, .data_wdata, .data_req_ready,
        .data_rsp_valid, .data_rdata,
        .d_valid, .d_op, .d_addr, .d_wdata, .d_accept, .d_rsp_valid, .d_rdata, .d_busy
    );

    port_arbiter #(.ADDR_W(ADDR_W)) u_arb (
        .clk, .rst,
        .f_valid, .f_addr, .f_accept, .f_rsp_valid, .f_rdata,
        .d_valid, .d_op, .d_addr, .d_wdata, .d_accept, .d_rsp_valid, .d_rdata,
        .f_busy, .d_busy,
        .mem_valid, .mem_op, .mem_addr, .mem_wdata, .mem_ready,
        .mem_rsp_valid, .mem_rdata,
        .freeze
    );

endmodule

/* logic/port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter #(
    parameter int ADDR_W = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           f_valid,
    input  logic [ADDR_W-1:0]              f_addr,
    output logic                           f_accept,
    output logic                           f_rsp_valid,
    output logic [mem_bus_pkg::DATA_W-1:0] f_rdata,
    input  logic                           d_valid,
    input  mem_bus_pkg::mem_op_e           d_op,
    input  logic [ADDR_W-1:0]              d_addr,
    input  logic [mem_bus_pkg::DATA_W-1:0] d_wdata,
    output logic                           d_accept,
    output logic                           d_rsp_valid,
    output logic [mem_bus_pkg::DATA_W-1:0] d_rdata,
    input  logic                           f_busy,
    input  logic                           d_busy,
    output logic                           mem_valid,
    output mem_bus_pkg::mem_op_e           mem_op,
    output logic [ADDR_W-1:0]              mem_addr,
    output logic [mem_bus_pkg::DATA_W-1:0] mem_wdata,
    input  logic                           mem_ready,
    input  logic                           mem_rsp_valid,
    input  logic [mem_bus_pkg::DATA_W-1:0] mem_rdata,
    output logic                           freeze
);
    import mem_bus_pkg::*;

    logic lock;       // Request on the bus not yet taken
    logic lock_d;     // Owner of the locked request
    logic out_valid;  // One transaction waiting for its response
    logic out_d;      // Owner of the outstanding transaction
    logic sel_d;
    logic hs;

    // Data beats fetch unless a fetch already sits on the bus
    assign sel_d = lock ? lock_d : d_valid;

    assign mem_valid = !out_valid && (d_valid || f_valid);
    assign mem_op    = sel_d ? d_op : OP_FETCH;
    assign mem_addr  = sel_d ? d_addr : f_addr;
    assign mem_wdata = sel_d ? d_wdata : '0;
    assign hs        = mem_valid && mem_ready;

    assign f_accept    = hs && !sel_d;
    assign d_accept    = hs && sel_d;
    assign f_rsp_valid = mem_rsp_valid && out_valid && !out_d;
    assign d_rsp_valid = mem_rsp_valid && out_valid && out_d;
    assign f_rdata     = mem_rdata;
    assign d_rdata     = mem_rdata;

    assign freeze = f_busy || d_busy || out_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lock      <= 1'b0;
            lock_d    <= 1'b0;
            out_valid <= 1'b0;
            out_d     <= 1'b0;
        end else begin
            lock <= mem_valid && !mem_ready;
            if (mem_valid)
                lock_d <= sel_d;
            if (hs) begin
                out_valid <= 1'b1;
                out_d     <= sel_d;
            end else if (mem_rsp_valid) begin
                out_valid <= 1'b0;
            end
        end
    end

    a_bus_stable: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_op)
            && $stable(mem_addr) && $stable(mem_wdata))
        else $error("bus request changed before mem_ready");

    a_no_orphan_rsp: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> out_valid)
        else $error("mem_rsp_valid with nothing outstanding");

endmodule

/* logic/data_requester.sv */
`timescale 1ns/1ps

module data_requester #(
    parameter int ADDR_W = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           data_req_valid,
    input  mem_bus_pkg::mem_op_e           data_op,
    input  logic [ADDR_W-1:0]              data_addr,
    input  logic [mem_bus_pkg::DATA_W-1:0] data_wdata,
    output logic                           data_req_ready,
    output logic                           data_rsp_valid,
    output logic [mem_bus_pkg::DATA_W-1:0] data_rdata,
    output logic                           d_valid,
    output mem_bus_pkg::mem_op_e           d_op,
    output logic [ADDR_W-1:0]              d_addr,
    output logic [mem_bus_pkg::DATA_W-1:0] d_wdata,
    input  logic                           d_accept,
    input  logic                           d_rsp_valid,
    input  logic [mem_bus_pkg::DATA_W-1:0] d_rdata,
    output logic                           d_busy
);
    import mem_bus_pkg::*;
    import core_req_pkg::*;

    data_state_e       state;
    mem_op_e           op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;
    logic              rsp_q;     // Completion pulse, loads and stores alike
    logic              take;

    assign take = (state == DS_IDLE) && data_req_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= DS_IDLE;
            rsp_q <= 1'b0;
        end else begin
            rsp_q <= (state == DS_WAIT) && d_rsp_valid;
            case (state)
                DS_IDLE: begin
                    if (data_req_valid)
                        state <= DS_REQ;
                end
                DS_REQ: begin
                    if (d_accept)
                        state <= DS_WAIT;
                end
                DS_WAIT: begin
                    if (d_rsp_valid)
                        state <= DS_IDLE;
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q    <= data_op;
            addr_q  <= data_addr;
            wdata_q <= data_wdata;
        end
        if (state == DS_WAIT && d_rsp_valid)
            rdata_q <= d_rdata;   // Don't care for stores
    end

    assign data_req_ready = (state == DS_IDLE);
    assign data_rsp_valid = rsp_q;
    assign data_rdata     = rdata_q;
    assign d_valid        = (state == DS_REQ);
    assign d_op           = op_q;
    assign d_addr         = addr_q;
    assign d_wdata        = wdata_q;
    assign d_busy         = (state != DS_IDLE);

    a_no_fetch_op: assert property (@(posedge clk) disable iff (rst)
        data_req_valid |-> data_op != OP_FETCH)
        else $error("core issued OP_FETCH on the data port");

endmodule

/* logic/fetch_requester.sv */
`timescale 1ns/1ps

module fetch_requester #(
    parameter int ADDR_W = 32
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_req_valid,
    input  logic [ADDR_W-1:0]           fetch_pc,
    output logic                        fetch_req_ready,
    input  logic                        redirect,
    input  logic [ADDR_W-1:0]           redirect_pc,
    output logic                        instr_valid,
    output logic [mem_bus_pkg::DATA_W-1:0] instr,
    input  logic                        instr_ready,
    output logic                        f_valid,
    output logic [ADDR_W-1:0]           f_addr,
    input  logic                        f_accept,
    input  logic                        f_rsp_valid,
    input  logic [mem_bus_pkg::DATA_W-1:0] f_rdata,
    output logic                        f_busy
);
    import mem_bus_pkg::*;
    import core_req_pkg::*;

    fetch_state_e      state;
    fetch_state_e      state_nxt;
    logic [ADDR_W-1:0] addr_q;      // Address presented on the bus
    logic [ADDR_W-1:0] target_q;    // Latest redirect target
    logic [DATA_W-1:0] instr_q;
    logic              redir_pend;  // Redirect seen before the bus took the request
    logic              refetch;     // Go fetch target_q once the NOP is taken
    logic              waiting;
    logic              stale;

    assign waiting = (state == FS_WAIT) || (state == FS_DISCARD);
    assign stale   = (state == FS_DISCARD) || redirect;

    always_comb begin
        state_nxt = state;
        case (state)
            FS_IDLE: begin
                if (fetch_req_valid)
                    state_nxt = FS_REQ;
            end
            FS_REQ: begin
                // Request fields stay put on the bus, so a redirect here squashes it later
                if (f_accept)
                    state_nxt = (redir_pend || redirect) ? FS_DISCARD : FS_WAIT;
            end
            FS_WAIT, FS_DISCARD: begin
                if (f_rsp_valid)
                    state_nxt = FS_HOLD;
                else if (redirect)
                    state_nxt = FS_DISCARD;
            end
            FS_HOLD: begin
                if (instr_ready)
                    state_nxt = refetch ? FS_REQ : FS_IDLE;
            end
            default: state_nxt = FS_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= FS_IDLE;
            redir_pend <= 1'b0;
            refetch    <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == FS_REQ)
                redir_pend <= (redir_pend || redirect) && !f_accept;
            if (waiting && f_rsp_valid)
                refetch <= stale;
            else if (state == FS_HOLD && instr_ready)
                refetch <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FS_IDLE && fetch_req_valid)
            addr_q <= fetch_pc;
        else if (state == FS_HOLD && instr_ready && refetch)
            addr_q <= redirect ? redirect_pc : target_q;  // Newest target wins
        if (redirect && state != FS_IDLE)
            target_q <= redirect_pc;
        if (waiting && f_rsp_valid)
            instr_q <= stale ? NOP_INSTR : f_rdata;
    end

    assign fetch_req_ready = (state == FS_IDLE);
    assign f_valid         = (state == FS_REQ);
    assign f_addr          = addr_q;
    assign instr_valid     = (state == FS_HOLD);
    assign instr           = instr_q;
    assign f_busy          = (state == FS_REQ) || waiting || refetch;

    a_req_held: assert property (@(posedge clk) disable iff (rst)
        f_valid && !f_accept |=> f_valid && $stable(f_addr))
        else $error("fetch request dropped before accept");

    a_instr_held: assert property (@(posedge clk) disable iff (rst)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr))
        else $error("held instruction changed under back-pressure");

endmodule

/* logic/core_req_pkg.sv */
package core_req_pkg;

    // Fetch side FSM
    typedef enum logic [2:0] {
        FS_IDLE    = 3'd0,  // Ready for a new PC
        FS_REQ     = 3'd1,  // Request presented to the arbiter
        FS_WAIT    = 3'd2,  // Accepted, waiting on the response
        FS_DISCARD = 3'd3,  // Response in flight is stale
        FS_HOLD    = 3'd4   // Instruction latched until the core takes it
    } fetch_state_e;

    // Load/store side FSM
    typedef enum logic [1:0] {
        DS_IDLE = 2'd0,
        DS_REQ  = 2'd1,
        DS_WAIT = 2'd2
    } data_state_e;

    // Bubble handed to the core in place of a squashed fetch (addi x0, x0, 0)
    localparam logic [mem_bus_pkg::DATA_W-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

/* logic/mem_bus_pkg.sv */
package mem_bus_pkg;

    // Instruction and data words share one width on the port
    parameter int DATA_W = 32;

    // Operation carried with every request on the shared port
    typedef enum logic [1:0] {
        OP_FETCH = 2'd0,  // Instruction read at the PC
        OP_LOAD  = 2'd1,  // Data read
        OP_STORE = 2'd2   // Data write, response carries no data
    } mem_op_e;

endpackage
